/* common/dsp_core_pkg.sv */
package dsp_core_pkg;

	localparam int data_width_default = 16;
	localparam int n_blocks_default = 16;

	// Channel fields in the instruction word are 4 bits wide
	localparam int n_channels = 16;
	localparam int channel_addr_w = 4;

	typedef enum logic [2:0] {
		op_nop = 3'd0,
		op_madd = 3'd1,
		op_macz = 3'd2,
		op_mac = 3'd3,
		op_mov_acc = 3'd4,
		op_mov = 3'd5
	} opcode_e;

	typedef struct packed {
		opcode_e opcode;
		logic [channel_addr_w-1:0] dest;
		logic [channel_addr_w-1:0] src_a;
		logic [channel_addr_w-1:0] src_b;
		logic [channel_addr_w-1:0] src_c;
		logic a_reg;
		logic b_reg;
		logic [4:0] shift;
		logic sat_disable;
		logic [4:0] spare;
	} instr_t;

	// Ops that leave a result in the channel file
	function automatic logic op_writes_channel(opcode_e op);
		return op inside {op_madd, op_mov_acc, op_mov};
	endfunction

	function automatic logic op_reads_a(opcode_e op);
		return op inside {op_madd, op_macz, op_mac, op_mov};
	endfunction

	function automatic logic op_reads_b(opcode_e op);
		return op inside {op_madd, op_macz, op_mac};
	endfunction

	// Only madd takes a third operand
	function automatic logic op_reads_c(opcode_e op);
		return op == op_madd;
	endfunction

endpackage

/* rtl/block_store.sv */
`timescale 1ns/100ps

module block_store import dsp_core_pkg::*; #(
	parameter int data_width = data_width_default,
	parameter int n_blocks = n_blocks_default
) (
	input logic clk,
	input logic reset,
	input logic busy,
	input logic cmd_instr_write,
	input logic cmd_reg_write,
	input logic [$clog2(n_blocks)-1:0] cmd_block,
	input logic cmd_reg_sel,
	input instr_t cmd_instr,
	input logic signed [data_width-1:0] cmd_reg_value,
	input logic [$clog2(n_blocks)-1:0] block_addr,
	output instr_t instr,
	output logic signed [data_width-1:0] coef_0,
	output logic signed [data_width-1:0] coef_1,
	output logic [$clog2(n_blocks):0] blocks_running
);

	localparam int block_addr_w = $clog2(n_blocks);

	instr_t instrs [n_blocks];
	logic signed [data_width-1:0] coefs_0 [n_blocks];
	logic signed [data_width-1:0] coefs_1 [n_blocks];

	logic [block_addr_w:0] cmd_count;

	assign cmd_count = {1'b0, cmd_block} + 1'b1;

	// Program is cleared to nops and zero coefficients on reset
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < n_blocks; i++) begin
				instrs[i] <= '0;
				coefs_0[i] <= '0;
				coefs_1[i] <= '0;
			end
			blocks_running <= '0;
		end else begin
			if (cmd_instr_write)
				instrs[cmd_block] <= cmd_instr;
			if (cmd_reg_write && !cmd_reg_sel)
				coefs_0[cmd_block] <= cmd_reg_value;
			if (cmd_reg_write && cmd_reg_sel)
				coefs_1[cmd_block] <= cmd_reg_value;
			// Pass length follows the highest block touched
			if ((cmd_instr_write || cmd_reg_write) && cmd_count > blocks_running)
				blocks_running <= cmd_count;
		end
	end

	always_ff @(posedge clk) begin
		instr <= instrs[block_addr];
		coef_0 <= coefs_0[block_addr];
		coef_1 <= coefs_1[block_addr];
	end

	// The program must not change under a running pass
	assert property (@(posedge clk) disable iff (reset)
		(cmd_instr_write || cmd_reg_write) |-> !busy);

endmodule

/* rtl/fetch_decode_stage.sv */
`timescale 1ns/100ps

module fetch_decode_stage import dsp_core_pkg::*; #(
	parameter int data_width = data_width_default,
	parameter int n_blocks = n_blocks_default
) (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic [$clog2(n_blocks):0] blocks_running,
	input instr_t instr,
	input logic signed [data_width-1:0] coef_0,
	input logic signed [data_width-1:0] coef_1,
	input logic fd_ready,
	input logic in_flight_empty,
	output logic [$clog2(n_blocks)-1:0] block_addr,
	output logic busy,
	output logic tick_accept,
	output logic fd_valid,
	output opcode_e opcode,
	output logic [channel_addr_w-1:0] dest,
	output logic [channel_addr_w-1:0] src_a,
	output logic [channel_addr_w-1:0] src_b,
	output logic [channel_addr_w-1:0] src_c,
	output logic a_reg,
	output logic b_reg,
	output logic [4:0] shift,
	output logic sat_disable,
	output logic signed [data_width-1:0] coef_0_out,
	output logic signed [data_width-1:0] coef_1_out
);

	localparam int block_addr_w = $clog2(n_blocks);

	typedef enum logic {st_idle, st_run} state_e;

	state_e state;
	logic [block_addr_w:0] next_blk;
	logic [block_addr_w-1:0] cur_blk;
	logic hold;
	logic more;
	logic fetch;

	assign busy = state == st_run;
	assign tick_accept = tick && state == st_idle;
	assign hold = fd_valid && !fd_ready;
	assign more = next_blk < blocks_running;
	assign fetch = busy && !hold && more;

	// While stalled the same block is read again so the store output stays put
	assign block_addr = hold ? cur_blk : next_blk[block_addr_w-1:0];

	always_ff @(posedge clk) begin
		cur_blk <= block_addr;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			fd_valid <= 1'b0;
			next_blk <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (tick) begin
						state <= st_run;
						next_blk <= '0;
					end
				end
				st_run: begin
					if (!hold) begin
						fd_valid <= fetch;
						if (fetch)
							next_blk <= next_blk + 1'b1;
					end
					if (!more && !fd_valid && in_flight_empty)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	assign opcode = instr.opcode;
	assign dest = instr.dest;
	assign src_a = instr.src_a;
	assign src_b = instr.src_b;
	assign src_c = instr.src_c;
	assign a_reg = instr.a_reg;
	assign b_reg = instr.b_reg;
	assign shift = instr.shift;
	assign sat_disable = instr.sat_disable;
	assign coef_0_out = coef_0;
	assign coef_1_out = coef_1;

	assert property (@(posedge clk) disable iff (reset) tick |-> !busy);

	// A stalled item must come back unchanged from the store
	assert property (@(posedge clk) disable iff (reset)
		hold |=> fd_valid && $stable(instr) && $stable(coef_0) && $stable(coef_1));

endmodule

/* rtl/operand_fetch_stage.sv */
`timescale 1ns/100ps

module operand_fetch_stage import dsp_core_pkg::*; #(
	parameter int data_width = data_width_default,
	parameter int n_blocks = n_blocks_default
) (
	input logic clk,
	input logic reset,
	input logic tick_accept,
	input logic signed [data_width-1:0] sample_in,
	output logic signed [data_width-1:0] sample_out,
	input logic fd_valid,
	output logic fd_ready,
	output logic in_flight_empty,
	input opcode_e opcode,
	input logic [channel_addr_w-1:0] dest,
	input logic [channel_addr_w-1:0] src_a,
	input logic [channel_addr_w-1:0] src_b,
	input logic [channel_addr_w-1:0] src_c,
	input logic a_reg,
	input logic b_reg,
	input logic [4:0] shift,
	input logic sat_disable,
	input logic signed [data_width-1:0] coef_0,
	input logic signed [data_width-1:0] coef_1,
	input logic wb_valid,
	input logic wb_write,
	input logic [channel_addr_w-1:0] wb_dest,
	input logic signed [data_width-1:0] wb_value,
	output logic ex_valid,
	output opcode_e ex_opcode,
	output logic [channel_addr_w-1:0] ex_dest,
	output logic [4:0] ex_shift,
	output logic ex_sat_disable,
	output logic signed [data_width-1:0] arg_a,
	output logic signed [data_width-1:0] arg_b,
	output logic signed [data_width-1:0] arg_c
);

	// Outstanding items never exceed one pass
	localparam int count_w = $clog2(n_blocks + 1);

	logic signed [data_width-1:0] channels [n_channels];
	logic [n_channels-1:0] pending;
	logic [count_w-1:0] in_flight;

	logic held_valid;
	opcode_e held_opcode;
	logic [channel_addr_w-1:0] held_dest;
	logic [channel_addr_w-1:0] held_src_a;
	logic [channel_addr_w-1:0] held_src_b;
	logic [channel_addr_w-1:0] held_src_c;
	logic held_a_reg;
	logic held_b_reg;
	logic [4:0] held_shift;
	logic held_sat_disable;
	logic signed [data_width-1:0] held_coef_0;
	logic signed [data_width-1:0] held_coef_1;

	logic uses_a;
	logic uses_b;
	logic uses_c;
	logic writes;
	logic hazard;

	assign uses_a = op_reads_a(held_opcode) && !held_a_reg;
	assign uses_b = op_reads_b(held_opcode) && !held_b_reg;
	assign uses_c = op_reads_c(held_opcode);
	assign writes = op_writes_channel(held_opcode);
	assign hazard = (uses_a && pending[held_src_a]) || (uses_b && pending[held_src_b]) ||
		(uses_c && pending[held_src_c]) || (writes && pending[held_dest]);

	assign ex_valid = held_valid && !hazard;
	assign fd_ready = !held_valid || ex_valid;
	assign in_flight_empty = !held_valid && in_flight == '0;

	always_ff @(posedge clk) begin
		if (reset)
			held_valid <= 1'b0;
		else if (fd_ready)
			held_valid <= fd_valid;
	end

	always_ff @(posedge clk) begin
		if (fd_ready && fd_valid) begin
			held_opcode <= opcode;
			held_dest <= dest;
			held_src_a <= src_a;
			held_src_b <= src_b;
			held_src_c <= src_c;
			held_a_reg <= a_reg;
			held_b_reg <= b_reg;
			held_shift <= shift;
			held_sat_disable <= sat_disable;
			held_coef_0 <= coef_0;
			held_coef_1 <= coef_1;
		end
	end

	assign ex_opcode = held_opcode;
	assign ex_dest = held_dest;
	assign ex_shift = held_shift;
	assign ex_sat_disable = held_sat_disable;
	assign arg_a = held_a_reg ? held_coef_0 : channels[held_src_a];
	assign arg_b = held_b_reg ? held_coef_1 : channels[held_src_b];
	assign arg_c = channels[held_src_c];

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= '0;
			in_flight <= '0;
		end else begin
			if (wb_valid && wb_write)
				pending[wb_dest] <= 1'b0;
			if (ex_valid && writes)
				pending[held_dest] <= 1'b1;
			if (ex_valid && !wb_valid)
				in_flight <= in_flight + 1'b1;
			else if (!ex_valid && wb_valid)
				in_flight <= in_flight - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < n_channels; i++)
				channels[i] <= '0;
			sample_out <= '0;
		end else begin
			if (wb_valid && wb_write)
				channels[wb_dest] <= wb_value;
			// Ticks only land between passes, so no writeback competes here
			if (tick_accept) begin
				sample_out <= channels[0];
				channels[0] <= sample_in;
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		wb_valid && wb_write |-> pending[wb_dest]);

	assert property (@(posedge clk) disable iff (reset) wb_valid |-> in_flight != '0);

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage import dsp_core_pkg::*; #(
	parameter int data_width = data_width_default
) (
	input logic clk,
	input logic reset,
	input logic ex_valid,
	input opcode_e ex_opcode,
	input logic [channel_addr_w-1:0] ex_dest,
	input logic [4:0] ex_shift,
	input logic ex_sat_disable,
	input logic signed [data_width-1:0] arg_a,
	input logic signed [data_width-1:0] arg_b,
	input logic signed [data_width-1:0] arg_c,
	output logic wb_valid,
	output logic wb_write,
	output logic [channel_addr_w-1:0] wb_dest,
	output logic signed [data_width-1:0] wb_value
);

	localparam int prod_width = 2 * data_width;
	localparam int acc_width = 2 * data_width + 8;

	localparam logic signed [acc_width-1:0] sat_max = 2 ** (data_width - 1) - 1;
	localparam logic signed [acc_width-1:0] sat_min = -(2 ** (data_width - 1));

	logic signed [prod_width-1:0] product;

	logic s1_valid;
	opcode_e s1_opcode;
	logic [channel_addr_w-1:0] s1_dest;
	logic s1_sat_disable;
	logic signed [prod_width-1:0] s1_prod;
	logic signed [data_width-1:0] s1_arg_a;
	logic signed [data_width-1:0] s1_arg_c;

	logic signed [acc_width-1:0] acc;
	logic signed [acc_width-1:0] acc_next;
	logic signed [acc_width-1:0] prod_ext;
	logic signed [acc_width-1:0] a_ext;
	logic signed [acc_width-1:0] c_ext;
	logic signed [acc_width-1:0] sum;
	logic signed [data_width-1:0] result;

	assign product = arg_a * arg_b;

	always_ff @(posedge clk) begin
		if (reset)
			s1_valid <= 1'b0;
		else
			s1_valid <= ex_valid;
	end

	always_ff @(posedge clk) begin
		s1_opcode <= ex_opcode;
		s1_dest <= ex_dest;
		s1_sat_disable <= ex_sat_disable;
		s1_prod <= product >>> ex_shift;
		s1_arg_a <= arg_a;
		s1_arg_c <= arg_c;
	end

	assign prod_ext = s1_prod;
	assign a_ext = s1_arg_a;
	assign c_ext = s1_arg_c;

	always_comb begin
		acc_next = acc;
		sum = '0;
		case (s1_opcode)
			op_madd: sum = prod_ext + c_ext;
			op_macz: acc_next = prod_ext;
			op_mac: acc_next = acc + prod_ext;
			op_mov_acc: sum = acc;
			op_mov: sum = a_ext;
			default: sum = '0;
		endcase
	end

	always_comb begin
		if (s1_sat_disable)
			result = sum[data_width-1:0];
		else if (sum > sat_max)
			result = sat_max[data_width-1:0];
		else if (sum < sat_min)
			result = sat_min[data_width-1:0];
		else
			result = sum[data_width-1:0];
	end

	// Accumulator only moves for valid items, so mov_acc sees every earlier mac
	always_ff @(posedge clk) begin
		if (reset) begin
			acc <= '0;
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= s1_valid;
			if (s1_valid)
				acc <= acc_next;
		end
	end

	always_ff @(posedge clk) begin
		wb_write <= op_writes_channel(s1_opcode);
		wb_dest <= s1_dest;
		wb_value <= result;
	end

endmodule

/* rtl/dsp_core.sv */
`timescale 1ns/100ps

module dsp_core import dsp_core_pkg::*; #(
	parameter int data_width = data_width_default,
	parameter int n_blocks = n_blocks_default
) (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic signed [data_width-1:0] sample_in,
	output logic signed [data_width-1:0] sample_out,
	output logic busy,
	input logic cmd_instr_write,
	input logic cmd_reg_write,
	input logic [$clog2(n_blocks)-1:0] cmd_block,
	input logic cmd_reg_sel,
	input instr_t cmd_instr,
	input logic signed [data_width-1:0] cmd_reg_value
);

	localparam int block_addr_w = $clog2(n_blocks);

	logic [block_addr_w-1:0] block_addr;
	logic [block_addr_w:0] blocks_running;
	instr_t instr;
	logic signed [data_width-1:0] coef_0;
	logic signed [data_width-1:0] coef_1;
	logic tick_accept;

	logic fd_valid;
	logic fd_ready;
	logic in_flight_empty;
	opcode_e fd_opcode;
	logic [channel_addr_w-1:0] fd_dest;
	logic [channel_addr_w-1:0] fd_src_a;
	logic [channel_addr_w-1:0] fd_src_b;
	logic [channel_addr_w-1:0] fd_src_c;
	logic fd_a_reg;
	logic fd_b_reg;
	logic [4:0] fd_shift;
	logic fd_sat_disable;
	logic signed [data_width-1:0] fd_coef_0;
	logic signed [data_width-1:0] fd_coef_1;

	logic ex_valid;
	opcode_e ex_opcode;
	logic [channel_addr_w-1:0] ex_dest;
	logic [4:0] ex_shift;
	logic ex_sat_disable;
	logic signed [data_width-1:0] arg_a;
	logic signed [data_width-1:0] arg_b;
	logic signed [data_width-1:0] arg_c;

	logic wb_valid;
	logic wb_write;
	logic [channel_addr_w-1:0] wb_dest;
	logic signed [data_width-1:0] wb_value;

	block_store #(.data_width(data_width), .n_blocks(n_blocks)) u_block_store (
		.clk(clk),
		.reset(reset),
		.busy(busy),
		.cmd_instr_write(cmd_instr_write),
		.cmd_reg_write(cmd_reg_write),
		.cmd_block(cmd_block),
		.cmd_reg_sel(cmd_reg_sel),
		.cmd_instr(cmd_instr),
		.cmd_reg_value(cmd_reg_value),
		.block_addr(block_addr),
		.instr(instr),
		.coef_0(coef_0),
		.coef_1(coef_1),
		.blocks_running(blocks_running)
	);

	fetch_decode_stage #(.data_width(data_width), .n_blocks(n_blocks)) u_fetch_decode (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.blocks_running(blocks_running),
		.instr(instr),
		.coef_0(coef_0),
		.coef_1(coef_1),
		.fd_ready(fd_ready),
		.in_flight_empty(in_flight_empty),
		.block_addr(block_addr),
		.busy(busy),
		.tick_accept(tick_accept),
		.fd_valid(fd_valid),
		.opcode(fd_opcode),
		.dest(fd_dest),
		.src_a(fd_src_a),
		.src_b(fd_src_b),
		.src_c(fd_src_c),
		.a_reg(fd_a_reg),
		.b_reg(fd_b_reg),
		.shift(fd_shift),
		.sat_disable(fd_sat_disable),
		.coef_0_out(fd_coef_0),
		.coef_1_out(fd_coef_1)
	);

	operand_fetch_stage #(.data_width(data_width), .n_blocks(n_blocks)) u_operand_fetch (
		.clk(clk),
		.reset(reset),
		.tick_accept(tick_accept),
		.sample_in(sample_in),
		.sample_out(sample_out),
		.fd_valid(fd_valid),
		.fd_ready(fd_ready),
		.in_flight_empty(in_flight_empty),
		.opcode(fd_opcode),
		.dest(fd_dest),
		.src_a(fd_src_a),
		.src_b(fd_src_b),
		.src_c(fd_src_c),
		.a_reg(fd_a_reg),
		.b_reg(fd_b_reg),
		.shift(fd_shift),
		.sat_disable(fd_sat_disable),
		.coef_0(fd_coef_0),
		.coef_1(fd_coef_1),
		.wb_valid(wb_valid),
		.wb_write(wb_write),
		.wb_dest(wb_dest),
		.wb_value(wb_value),
		.ex_valid(ex_valid),
		.ex_opcode(ex_opcode),
		.ex_dest(ex_dest),
		.ex_shift(ex_shift),
		.ex_sat_disable(ex_sat_disable),
		.arg_a(arg_a),
		.arg_b(arg_b),
		.arg_c(arg_c)
	);

	execute_stage #(.data_width(data_width)) u_execute (
		.clk(clk),
		.reset(reset),
		.ex_valid(ex_valid),
		.ex_opcode(ex_opcode),
		.ex_dest(ex_dest),
		.ex_shift(ex_shift),
		.ex_sat_disable(ex_sat_disable),
		.arg_a(arg_a),
		.arg_b(arg_b),
		.arg_c(arg_c),
		.wb_valid(wb_valid),
		.wb_write(wb_write),
		.wb_dest(wb_dest),
		.wb_value(wb_value)
	);

endmodule

/* sim/dsp_core_tests.svh */
localparam int n_tests = 10;
localparam int max_words = 8;

string row_name [n_tests];
int row_words [n_tests];
bit row_random [n_tests];
logic signed [data_width-1:0] row_sample_a [n_tests];
logic signed [data_width-1:0] row_sample_b [n_tests];
logic signed [data_width-1:0] row_expected [n_tests];

// One entry per written block, in write order
instr_t word_instr [n_tests][max_words];
int word_block [n_tests][max_words];
logic signed [data_width-1:0] word_coef_0 [n_tests][max_words];
logic signed [data_width-1:0] word_coef_1 [n_tests][max_words];

task automatic set_row(input int t, input string name,
		input logic signed [data_width-1:0] sample_a,
		input logic signed [data_width-1:0] sample_b,
		input logic signed [data_width-1:0] expected, input bit use_random);
	row_name[t] = name;
	row_sample_a[t] = sample_a;
	row_sample_b[t] = sample_b;
	row_expected[t] = expected;
	row_random[t] = use_random;
	row_words[t] = 0;
endtask

task automatic set_word(input int t, input int blk, input instr_t w,
		input logic signed [data_width-1:0] c0, input logic signed [data_width-1:0] c1);
	word_block[t][row_words[t]] = blk;
	word_instr[t][row_words[t]] = w;
	word_coef_0[t][row_words[t]] = c0;
	word_coef_1[t][row_words[t]] = c1;
	row_words[t] = row_words[t] + 1;
endtask

// Arguments of make_instr: op, dest, src_a, src_b, src_c, a_reg, b_reg, shift, sat_disable
task automatic fill_tests;
	set_row(0, "mov from coefficient and channels", 16'sd55, 16'sd77, 16'sd1234, 1'b0);
	set_word(0, 0, make_instr(op_mov, 1, 0, 0, 0, 1, 0, 0, 0), 16'sd1234, 16'sd0);
	set_word(0, 1, make_instr(op_mov, 2, 1, 0, 0, 0, 0, 0, 0), 16'sd0, 16'sd0);
	set_word(0, 2, make_instr(op_mov, 0, 2, 0, 0, 0, 0, 0, 0), 16'sd0, 16'sd0);
	set_row(1, "madd with shift", 16'sd100, 16'sd0, 16'sd3850, 1'b0);
	set_word(1, 0, make_instr(op_madd, 0, 0, 0, 0, 1, 1, 4, 0), 16'sd300, 16'sd200);
	set_row(2, "madd positive saturation", 16'sd1000, 16'sd0, 16'sh7fff, 1'b0);
	set_word(2, 0, make_instr(op_madd, 0, 0, 0, 0, 1, 1, 0, 0), 16'sd30000, 16'sd30000);
	set_row(3, "madd negative saturation", 16'sd5, 16'sd0, 16'sh8000, 1'b0);
	set_word(3, 0, make_instr(op_madd, 0, 0, 0, 0, 1, 1, 0, 0), -16'sd30000, 16'sd30000);
	set_row(4, "madd wrap without saturation", 16'sd100, 16'sd0, 16'sh9ca4, 1'b0);
	set_word(4, 0, make_instr(op_madd, 0, 0, 0, 0, 1, 1, 0, 1), 16'sd200, 16'sd200);
	set_row(5, "macz mac mac mov_acc random", 16'sd321, 16'sd0, 16'sd0, 1'b1);
	set_word(5, 0, make_instr(op_macz, 0, 0, 0, 0, 1, 1, 14, 0), 16'sd0, 16'sd0);
	set_word(5, 1, make_instr(op_mac, 0, 0, 0, 0, 0, 1, 14, 0), 16'sd0, 16'sd0);
	set_word(5, 2, make_instr(op_mac, 0, 0, 0, 0, 1, 1, 14, 0), 16'sd0, 16'sd0);
	set_word(5, 3, make_instr(op_mov_acc, 0, 0, 0, 0, 0, 0, 0, 0), 16'sd0, 16'sd0);
	set_row(6, "mac chain around madd random", -16'sd45, 16'sd0, 16'sd0, 1'b1);
	set_word(6, 0, make_instr(op_macz, 0, 0, 0, 0, 1, 1, 9, 0), 16'sd0, 16'sd0);
	set_word(6, 1, make_instr(op_madd, 1, 0, 0, 0, 0, 1, 0, 0), 16'sd0, 16'sd0);
	set_word(6, 2, make_instr(op_mac, 0, 1, 0, 0, 0, 1, 9, 0), 16'sd0, 16'sd0);
	set_word(6, 3, make_instr(op_mov_acc, 0, 0, 0, 0, 0, 0, 0, 1), 16'sd0, 16'sd0);
	set_row(7, "back-to-back dependent ops", 16'sd7, 16'sd0, 16'shfd52, 1'b0);
	set_word(7, 0, make_instr(op_madd, 1, 0, 0, 0, 0, 1, 0, 0), 16'sd0, 16'sd3);
	set_word(7, 1, make_instr(op_madd, 2, 1, 0, 1, 0, 1, 0, 0), 16'sd0, 16'sd2);
	set_word(7, 2, make_instr(op_madd, 3, 2, 0, 0, 0, 1, 0, 0), 16'sd0, -16'sd1);
	set_word(7, 3, make_instr(op_mov, 0, 3, 0, 0, 0, 0, 0, 0), 16'sd0, 16'sd0);
	set_word(7, 4, make_instr(op_madd, 0, 0, 0, 2, 0, 1, 0, 0), 16'sd0, 16'sd10);
	set_row(8, "gap of unwritten blocks", 16'sd9, 16'sd0, 16'sd500, 1'b0);
	set_word(8, 0, make_instr(op_mov, 1, 0, 0, 0, 1, 0, 0, 0), 16'sd500, 16'sd0);
	set_word(8, 5, make_instr(op_mov, 0, 1, 0, 0, 0, 0, 0, 0), 16'sd0, 16'sd0);
	set_row(9, "channels cleared by reset", 16'sd42, 16'sd0, 16'sd0, 1'b0);
	set_word(9, 0, make_instr(op_madd, 0, 1, 0, 2, 0, 1, 0, 0), 16'sd0, 16'sd1);
endtask

/* sim/dsp_core_tb.sv */
`timescale 1ns/100ps

module dsp_core_tb import dsp_core_pkg::*; ();

	localparam int data_width = data_width_default;
	localparam int n_blocks = n_blocks_default;
	localparam int block_addr_w = $clog2(n_blocks);
	localparam int clk_period = 8;
	localparam int pass_limit = 200;
	localparam int row_cycles = 500;
	// Pads the 2*data_width+8 bit accumulator out to a 64-bit longint
	localparam int acc_pad = 64 - (2 * data_width + 8);

	logic clk;
	logic reset;
	logic tick;
	logic signed [data_width-1:0] sample_in;
	logic signed [data_width-1:0] sample_out;
	logic busy;
	logic cmd_instr_write;
	logic cmd_reg_write;
	logic [block_addr_w-1:0] cmd_block;
	logic cmd_reg_sel;
	instr_t cmd_instr;
	logic signed [data_width-1:0] cmd_reg_value;

	instr_t prog_instr [n_blocks];
	logic signed [data_width-1:0] prog_coef_0 [n_blocks];
	logic signed [data_width-1:0] prog_coef_1 [n_blocks];
	int prog_length;

	integer seed;
	int errors;
	int passed;
	int failed;
	int errors_before;
	logic signed [data_width-1:0] expected;
	logic signed [data_width-1:0] model_value;

	`include "dsp_core_tests.svh"

	dsp_core #(.data_width(data_width), .n_blocks(n_blocks)) uut (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.sample_in(sample_in),
		.sample_out(sample_out),
		.busy(busy),
		.cmd_instr_write(cmd_instr_write),
		.cmd_reg_write(cmd_reg_write),
		.cmd_block(cmd_block),
		.cmd_reg_sel(cmd_reg_sel),
		.cmd_instr(cmd_instr),
		.cmd_reg_value(cmd_reg_value)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		#(n_tests * row_cycles * clk_period);
		$display("Watchdog expired: the run took longer than its time bound");
		$display("*** FAILED ***");
		$finish;
	end

	function automatic instr_t make_instr(input opcode_e op, input int dest, input int src_a,
			input int src_b, input int src_c, input bit a_reg, input bit b_reg,
			input int shift, input bit sat_disable);
		instr_t w;
		w = '0;
		w.opcode = op;
		w.dest = dest[channel_addr_w-1:0];
		w.src_a = src_a[channel_addr_w-1:0];
		w.src_b = src_b[channel_addr_w-1:0];
		w.src_c = src_c[channel_addr_w-1:0];
		w.a_reg = a_reg;
		w.b_reg = b_reg;
		w.shift = shift[4:0];
		w.sat_disable = sat_disable;
		return w;
	endfunction

	function automatic logic signed [data_width-1:0] clamp_result(input longint sum,
			input bit wrap);
		longint max_v;
		longint min_v;
		max_v = (longint'(1) <<< (data_width - 1)) - 1;
		min_v = -(longint'(1) <<< (data_width - 1));
		if (wrap)
			return sum[data_width-1:0];
		if (sum > max_v)
			return max_v[data_width-1:0];
		if (sum < min_v)
			return min_v[data_width-1:0];
		return sum[data_width-1:0];
	endfunction

	// Runs one pass in program order and returns channel 0 afterwards
	function automatic logic signed [data_width-1:0] reference_result(
			input logic signed [data_width-1:0] sample);
		longint ch [n_channels];
		longint acc;
		longint a;
		longint b;
		longint c;
		longint p;
		longint sum;
		bit writes;
		instr_t w;
		for (int i = 0; i < n_channels; i++)
			ch[i] = 0;
		ch[0] = sample;
		acc = 0;
		for (int blk = 0; blk < prog_length; blk++) begin
			w = prog_instr[blk];
			a = w.a_reg ? longint'(prog_coef_0[blk]) : ch[w.src_a];
			b = w.b_reg ? longint'(prog_coef_1[blk]) : ch[w.src_b];
			c = ch[w.src_c];
			p = (a * b) >>> w.shift;
			sum = 0;
			writes = 1'b0;
			case (w.opcode)
				op_madd: begin
					sum = p + c;
					writes = 1'b1;
				end
				op_macz: acc = p;
				op_mac: acc = ((acc + p) <<< acc_pad) >>> acc_pad;
				op_mov_acc: begin
					sum = acc;
					writes = 1'b1;
				end
				op_mov: begin
					sum = a;
					writes = 1'b1;
				end
				default: writes = 1'b0;
			endcase
			if (writes)
				ch[w.dest] = clamp_result(sum, w.sat_disable);
		end
		return ch[0][data_width-1:0];
	endfunction

	task automatic build_program(input int t);
		int blk;
		int rnd;
		for (int b = 0; b < n_blocks; b++) begin
			prog_instr[b] = '0;
			prog_coef_0[b] = '0;
			prog_coef_1[b] = '0;
		end
		prog_length = 0;
		for (int i = 0; i < row_words[t]; i++) begin
			blk = word_block[t][i];
			prog_instr[blk] = word_instr[t][i];
			prog_coef_0[blk] = word_coef_0[t][i];
			prog_coef_1[blk] = word_coef_1[t][i];
			if (row_random[t]) begin
				rnd = $random(seed);
				prog_coef_0[blk] = rnd[data_width-1:0];
				rnd = $random(seed);
				prog_coef_1[blk] = rnd[data_width-1:0];
			end
			if (blk + 1 > prog_length)
				prog_length = blk + 1;
		end
	endtask

	task automatic do_reset;
		@(negedge clk);
		reset = 1'b1;
		repeat (3) @(negedge clk);
		reset = 1'b0;
	endtask

	// Writes the instruction and both coefficients in three command cycles
	task automatic write_block(input int blk);
		@(negedge clk);
		cmd_block = blk[block_addr_w-1:0];
		cmd_instr_write = 1'b1;
		cmd_instr = prog_instr[blk];
		@(negedge clk);
		cmd_instr_write = 1'b0;
		cmd_reg_write = 1'b1;
		cmd_reg_sel = 1'b0;
		cmd_reg_value = prog_coef_0[blk];
		@(negedge clk);
		cmd_reg_sel = 1'b1;
		cmd_reg_value = prog_coef_1[blk];
		@(negedge clk);
		cmd_reg_write = 1'b0;
	endtask

	task automatic wait_idle(output bit timed_out);
		int cycles;
		cycles = 0;
		timed_out = 1'b0;
		while (busy && !timed_out) begin
			@(negedge clk);
			cycles++;
			if (cycles > pass_limit)
				timed_out = 1'b1;
		end
	endtask

	task automatic run_pass(input int t, input logic signed [data_width-1:0] sample,
			input logic signed [data_width-1:0] want);
		bit timed_out;
		@(negedge clk);
		tick = 1'b1;
		sample_in = sample;
		@(negedge clk);
		tick = 1'b0;
		if (!busy) begin
			$display("Error at %0t ns: test %0d busy did not rise after a tick", $time, t);
			errors++;
		end
		if (sample_out !== want) begin
			$display("Error at %0t ns: test %0d sample_out is %0d, expected %0d",
				$time, t, sample_out, want);
			errors++;
		end
		wait_idle(timed_out);
		if (timed_out) begin
			$display("Test %0d hung: busy stayed high past the pass limit", t);
			errors++;
		end
	endtask

	initial begin
		reset = 1'b1;
		tick = 1'b0;
		sample_in = '0;
		cmd_instr_write = 1'b0;
		cmd_reg_write = 1'b0;
		cmd_block = '0;
		cmd_reg_sel = 1'b0;
		cmd_instr = '0;
		cmd_reg_value = '0;
		seed = 95;
		errors = 0;
		passed = 0;
		failed = 0;
		fill_tests();

		for (int t = 0; t < n_tests; t++) begin
			errors_before = errors;
			build_program(t);
			model_value = reference_result(row_sample_a[t]);
			expected = row_random[t] ? model_value : row_expected[t];
			if (!row_random[t] && model_value !== row_expected[t]) begin
				$display("Error at %0t ns: test %0d model gives %0d, table expects %0d",
					$time, t, model_value, row_expected[t]);
				errors++;
			end
			do_reset();
			if (sample_out !== '0 || busy !== 1'b0) begin
				$display("Error at %0t ns: test %0d sample_out is %0d and busy is %b after reset",
					$time, t, sample_out, busy);
				errors++;
			end
			for (int i = 0; i < row_words[t]; i++)
				write_block(word_block[t][i]);
			// First tick shows channel 0 as left by reset
			run_pass(t, row_sample_a[t], '0);
			run_pass(t, row_sample_b[t], expected);
			if (errors == errors_before) begin
				passed++;
				$display("Test %0d %s: ok", t, row_name[t]);
			end else begin
				failed++;
				$display("Test %0d %s: failed", t, row_name[t]);
			end
		end

		$display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
			n_tests, passed, failed, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* dsp_core.f */
+incdir+sim
common/dsp_core_pkg.sv
rtl/block_store.sv
rtl/fetch_decode_stage.sv
rtl/operand_fetch_stage.sv
rtl/execute_stage.sv
rtl/dsp_core.sv
sim/dsp_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
FILE_LIST ?= dsp_core.f
TB_TOP ?= dsp_core_tb
RTL_TOP ?= dsp_core
OBJ_DIR ?= obj_dir
LOG ?= sim.log
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
FAIL_MSG ?= *** FAILED ***

SRCS := $(wildcard common/*.sv rtl/*.sv sim/*.sv sim/*.svh)
BIN := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)

$(BIN): $(SRCS) $(FILE_LIST)
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: $(BIN)
	$(BIN) > $(LOG) 2>&1 || { cat $(LOG); echo "Simulator exited with an error"; exit 1; }
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@echo "No failure found in $(LOG)"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
